// File: files.f
rtl/core_pkg.sv
rtl/bridge_reg_file.sv
rtl/mclk_gen.sv
rtl/i2s_clock_tx.sv
rtl/frame_counter.sv
rtl/bridge_read_mux.sv
rtl/core_top.sv
verif/tb_core_top.sv

// File: rtl/bridge_read_mux.sv
//////////////////////////////////////////////////
// bridge read mux
// picks the read word for the current address
// from the registers and the frame count
//////////////////////////////////////////////////

`timescale 1ns/10ps

module bridge_read_mux (
    input  logic [31:0]                  addr,
    input  core_pkg::cfg_regs_t          regs,
    input  logic [core_pkg::FRAME_W-1:0] frame_count,
    output logic [31:0]                  rd_data
);

    localparam int FW = core_pkg::FRAME_W;

    // purely combinational, valid in the address cycle
    // rd strobe is not needed here
    always_comb begin
        case (addr)
            // narrow fields zero extended
            core_pkg::ADDR_CHAN_EN: begin
                rd_data = {29'd0, regs.chan_en};
            end
            core_pkg::ADDR_ANIM_EN: begin
                rd_data = {31'd0, regs.anim_en};
            end
            core_pkg::ADDR_DEBUG: begin
                rd_data = regs.debug_value;
            end
            // raw bits of the signed word
            core_pkg::ADDR_SIGNED: begin
                rd_data = regs.signed_value;
            end
            core_pkg::ADDR_FRAME_CNT: begin
                rd_data = {{(32 - FW){1'b0}}, frame_count};
            end
            // unmapped, command slots and the 0xF8 window
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

// File: rtl/bridge_reg_file.sv
//////////////////////////////////////////////////
// bridge register file
// decodes host writes into the config registers
// and the frame clear / increment pulses
//////////////////////////////////////////////////

`timescale 1ns/10ps

module bridge_reg_file (
    input  logic                  clk_74a,
    input  logic                  rst,
    input  core_pkg::bridge_req_t bridge,
    output core_pkg::cfg_regs_t   regs,
    output core_pkg::frame_cmd_t  frame_cmd
);

    // command slot hits
    logic hit_frame_rst;
    logic hit_frame_inc;

    assign hit_frame_rst = bridge.wr && (bridge.addr == core_pkg::ADDR_FRAME_RST);
    assign hit_frame_inc = bridge.wr && (bridge.addr == core_pkg::ADDR_FRAME_INC);

    //////////////////////////////////////////////////
    // configuration registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            regs.chan_en      <= core_pkg::RST_CHAN_EN;
            regs.anim_en      <= core_pkg::RST_ANIM_EN;
            regs.debug_value  <= core_pkg::RST_DEBUG;
            regs.signed_value <= '0;
        end else if (bridge.wr) begin
            case (bridge.addr)
                // narrow fields keep only the low bits
                core_pkg::ADDR_CHAN_EN: begin
                    regs.chan_en <= bridge.wr_data[2:0];
                end
                core_pkg::ADDR_ANIM_EN: begin
                    regs.anim_en <= bridge.wr_data[0];
                end
                // full 32-bit words
                core_pkg::ADDR_DEBUG: begin
                    regs.debug_value <= bridge.wr_data;
                end
                core_pkg::ADDR_SIGNED: begin
                    regs.signed_value <= bridge.wr_data;
                end
                // commands and unmapped addresses
                default: begin
                    regs <= regs;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // frame command pulses
    //////////////////////////////////////////////////

    // high for exactly the cycle after the write
    always_ff @(posedge clk_74a) begin
        if (rst) begin
            frame_cmd <= '0;
        end else begin
            frame_cmd.clear <= hit_frame_rst;
            frame_cmd.incr  <= hit_frame_inc;
        end
    end

endmodule

// File: rtl/core_pkg.sv
//////////////////////////////////////////////////
// core package
// bridge register map, reset values and the
// packed structs shared by bridge and audio logic
//////////////////////////////////////////////////

package core_pkg;

    //////////////////////////////////////////////////
    // bridge bus
    //////////////////////////////////////////////////

    // one bridge transfer as seen on clk_74a
    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
        logic        wr;
        logic [31:0] wr_data;
    } bridge_req_t;

    // configuration registers
    localparam logic [31:0] ADDR_CHAN_EN   = 32'h00F0000C;
    localparam logic [31:0] ADDR_ANIM_EN   = 32'h00100000;
    localparam logic [31:0] ADDR_DEBUG     = 32'h00100004;
    localparam logic [31:0] ADDR_SIGNED    = 32'h00300000;

    // write-only command slots
    localparam logic [31:0] ADDR_FRAME_RST = 32'h00F00014;
    localparam logic [31:0] ADDR_FRAME_INC = 32'h00F00018;

    // read-only frame count
    localparam logic [31:0] ADDR_FRAME_CNT = 32'h20000000;

    //////////////////////////////////////////////////
    // register contents
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [2:0]         chan_en;
        logic               anim_en;
        logic [31:0]        debug_value;
        logic signed [31:0] signed_value;
    } cfg_regs_t;

    // subset handed to the video side
    typedef struct packed {
        logic [2:0] chan_en;
        logic       anim_en;
    } video_cfg_t;

    // power-up contents, signed value starts at zero
    localparam logic [2:0]  RST_CHAN_EN = 3'b111;
    localparam logic        RST_ANIM_EN = 1'b1;
    localparam logic [31:0] RST_DEBUG   = 32'h12005678;

    //////////////////////////////////////////////////
    // frame and audio
    //////////////////////////////////////////////////

    // one-cycle command pulses
    typedef struct packed {
        logic clear;
        logic incr;
    } frame_cmd_t;

    localparam int FRAME_W = 16;

    // i2s clock pins
    typedef struct packed {
        logic mclk;
        logic sclk;
        logic lrck;
    } i2s_clk_t;

    // mclk phase accumulator width
    localparam int ACC_W = 22;

endpackage

// File: rtl/core_top.sv
//////////////////////////////////////////////////
// core top
// bridge register block beside the silent i2s
// clock path, joined by the bridge read mux
//////////////////////////////////////////////////

`timescale 1ns/10ps

module core_top #(
    parameter int ACC_STEP  = 245760,
    parameter int ACC_WRAP  = 742500,
    parameter int SLOT_BITS = 32
) (
    input  logic                  clk_74a,
    input  logic                  rst,
    input  core_pkg::bridge_req_t bridge,
    output logic [31:0]           bridge_rd_data,
    output core_pkg::video_cfg_t  video_cfg,
    output core_pkg::i2s_clk_t    audio
);

    //////////////////////////////////////////////////
    // bridge side
    //////////////////////////////////////////////////

    core_pkg::cfg_regs_t          regs;
    core_pkg::frame_cmd_t         frame_cmd;
    logic [core_pkg::FRAME_W-1:0] frame_count;

    bridge_reg_file u_reg_file (
        .clk_74a   (clk_74a),
        .rst       (rst),
        .bridge    (bridge),
        .regs      (regs),
        .frame_cmd (frame_cmd)
    );

    // video only sees the enables
    assign video_cfg = '{chan_en: regs.chan_en, anim_en: regs.anim_en};

    //////////////////////////////////////////////////
    // audio clock path
    //////////////////////////////////////////////////

    logic mclk;
    logic mclk_rise;
    logic frame_done;

    mclk_gen #(
        .ACC_STEP (ACC_STEP),
        .ACC_WRAP (ACC_WRAP)
    ) u_mclk_gen (
        .clk_74a   (clk_74a),
        .rst       (rst),
        .mclk      (mclk),
        .mclk_rise (mclk_rise)
    );

    i2s_clock_tx #(
        .SLOT_BITS (SLOT_BITS)
    ) u_i2s_clock_tx (
        .clk_74a    (clk_74a),
        .rst        (rst),
        .mclk       (mclk),
        .mclk_rise  (mclk_rise),
        .audio      (audio),
        .frame_done (frame_done)
    );

    // frame count stays in clk_74a, no sync needed
    frame_counter u_frame_counter (
        .clk_74a    (clk_74a),
        .rst        (rst),
        .frame_cmd  (frame_cmd),
        .frame_done (frame_done),
        .count      (frame_count)
    );

    // read data for the host
    bridge_read_mux u_read_mux (
        .addr        (bridge.addr),
        .regs        (regs),
        .frame_count (frame_count),
        .rd_data     (bridge_rd_data)
    );

endmodule

// File: rtl/frame_counter.sv
//////////////////////////////////////////////////
// frame counter
// counts stereo audio frames with host clear
// and increment commands
//////////////////////////////////////////////////

`timescale 1ns/10ps

module frame_counter (
    input  logic                          clk_74a,
    input  logic                          rst,
    input  core_pkg::frame_cmd_t          frame_cmd,
    input  logic                          frame_done,
    output logic [core_pkg::FRAME_W-1:0]  count
);

    localparam int W = core_pkg::FRAME_W;

    // host increment and frame end may land together
    logic [W-1:0] step;

    assign step = W'(frame_cmd.incr) + W'(frame_done);

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            count <= '0;
        end else if (frame_cmd.clear) begin
            // clear beats any increment in the same cycle
            count <= '0;
        end else begin
            // wraps at full width
            count <= count + step;
        end
    end

endmodule

// File: rtl/i2s_clock_tx.sv
//////////////////////////////////////////////////
// i2s clock transmitter
// mclk / 4 gives sclk, lrck flips every slot
// frame_done marks the end of each stereo frame
//////////////////////////////////////////////////

`timescale 1ns/10ps

module i2s_clock_tx #(
    parameter int SLOT_BITS = 32
) (
    input  logic               clk_74a,
    input  logic               rst,
    input  logic               mclk,
    input  logic               mclk_rise,
    output core_pkg::i2s_clk_t audio,
    output logic               frame_done
);

    localparam int CNT_W = (SLOT_BITS > 1) ? $clog2(SLOT_BITS) : 1;
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SLOT_BITS - 1);

    // mclk divider, top bit is sclk
    logic [1:0]       div;
    // bit position inside the channel slot
    logic [CNT_W-1:0] bit_cnt;
    logic             lrck;
    // divider wrap 3 -> 0 is the sclk falling edge
    logic             sclk_fall;
    // last bit of the slot done
    logic             slot_end;

    assign sclk_fall = mclk_rise && (div == 2'd3);
    assign slot_end  = sclk_fall && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            div        <= '0;
            bit_cnt    <= '0;
            lrck       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // right slot closing means lrck goes 1 -> 0
            frame_done <= slot_end && lrck;
            if (mclk_rise) begin
                div <= div + 2'd1;
            end
            if (sclk_fall) begin
                bit_cnt <= slot_end ? '0 : bit_cnt + 1'b1;
            end
            if (slot_end) begin
                lrck <= ~lrck;
            end
        end
    end

    // dac data stays silent so only the clocks leave
    assign audio = '{mclk: mclk, sclk: div[1], lrck: lrck};

endmodule

// File: rtl/mclk_gen.sv
//////////////////////////////////////////////////
// mclk generator
// fractional accumulator toggling mclk off clk_74a
//////////////////////////////////////////////////

`timescale 1ns/10ps

module mclk_gen #(
    parameter int ACC_STEP = 245760,
    parameter int ACC_WRAP = 742500
) (
    input  logic clk_74a,
    input  logic rst,
    output logic mclk,
    output logic mclk_rise
);

    localparam int W = core_pkg::ACC_W;
    localparam logic [W-1:0] STEP = W'(ACC_STEP);
    localparam logic [W-1:0] WRAP = W'(ACC_WRAP);

    // phase accumulator
    logic [W-1:0] acc;
    // accumulator crossed the wrap point
    logic         wrap;

    assign wrap = (acc >= WRAP);

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            acc       <= '0;
            mclk      <= 1'b0;
            mclk_rise <= 1'b0;
        end else begin
            // strobe lines up with the first cycle mclk reads 1
            mclk_rise <= wrap && !mclk;
            if (wrap) begin
                // carry the remainder so the average rate stays exact
                acc  <= acc - WRAP + STEP;
                mclk <= ~mclk;
            end else begin
                acc <= acc + STEP;
            end
        end
    end

endmodule

// File: verif/tb_core_top.sv
//////////////////////////////////////////////////
// core top testbench
// random bridge traffic and frame commands, with
// a cycle model of registers and i2s clocks
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_core_top;

    localparam int ACC_STEP  = 245760;
    localparam int ACC_WRAP  = 742500;
    localparam int SLOT_BITS = 32;
    localparam int TIMEOUT   = 4000;

    // model of the audio clock chain
    typedef struct packed {
        logic [31:0] acc;
        logic        mclk;
        logic        rise;
        logic [1:0]  div;
        logic [5:0]  bit_cnt;
        logic        lrck;
        logic        frame_done;
    } audio_state_t;

    logic                  clk_74a;
    logic                  rst;
    core_pkg::bridge_req_t bridge;
    logic [31:0]           bridge_rd_data;
    core_pkg::video_cfg_t  video_cfg;
    core_pkg::i2s_clk_t    audio;

    // reference model state
    core_pkg::cfg_regs_t m_regs;
    logic                m_clear;
    logic                m_incr;
    audio_state_t        m_audio;
    logic [15:0]         m_count;

    logic [31:0] lfsr;
    logic        prev_sclk;
    logic        prev_lrck;
    int          sclk_falls;
    int          lrck_toggles;

    core_top #(
        .ACC_STEP  (ACC_STEP),
        .ACC_WRAP  (ACC_WRAP),
        .SLOT_BITS (SLOT_BITS)
    ) uut (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .video_cfg      (video_cfg),
        .audio          (audio)
    );

    initial clk_74a = 1'b0;
    always #5 clk_74a = ~clk_74a;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_plain(input string what);
        $display("error at %0t: %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // next audio state from the clocking rules
    function automatic audio_state_t audio_step(audio_state_t s);
        audio_state_t n;
        logic         wrap;
        logic         fall;
        logic         slot_end;
        n        = s;
        wrap     = (s.acc >= ACC_WRAP);
        fall     = s.rise && (s.div == 2'd3);
        slot_end = fall && (s.bit_cnt == SLOT_BITS - 1);
        if (wrap) begin
            n.acc  = s.acc - ACC_WRAP + ACC_STEP;
            n.mclk = ~s.mclk;
        end else begin
            n.acc = s.acc + ACC_STEP;
        end
        n.rise = wrap && !s.mclk;
        if (s.rise) begin
            n.div = s.div + 2'd1;
        end
        if (fall) begin
            n.bit_cnt = slot_end ? 6'd0 : s.bit_cnt + 6'd1;
        end
        if (slot_end) begin
            n.lrck = ~s.lrck;
        end
        n.frame_done = slot_end && s.lrck;
        return n;
    endfunction

    // lrck falls on the edge that leaves this state
    function automatic logic frame_ends_from(audio_state_t s);
        return s.rise && (s.div == 2'd3) && (s.bit_cnt == SLOT_BITS - 1) && s.lrck;
    endfunction

    // expected read word for an address
    function automatic logic [31:0] model_read(logic [31:0] a);
        case (a)
            core_pkg::ADDR_CHAN_EN:   return {29'd0, m_regs.chan_en};
            core_pkg::ADDR_ANIM_EN:   return {31'd0, m_regs.anim_en};
            core_pkg::ADDR_DEBUG:     return m_regs.debug_value;
            core_pkg::ADDR_SIGNED:    return m_regs.signed_value;
            core_pkg::ADDR_FRAME_CNT: return {16'd0, m_count};
            default:                  return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [1:0]  kind;
        logic [31:0] a;
        kind = 2'(rand_bits(2));
        case (kind)
            2'd0:    a = {8'hF8, 24'(rand_bits(24))};
            2'd1:    a = rand_bits(1) ? core_pkg::ADDR_FRAME_RST : core_pkg::ADDR_FRAME_INC;
            default: a = rand_bits(32);
        endcase
        // a random hit on the map falls back to the 0xF8 window
        if (a == core_pkg::ADDR_CHAN_EN || a == core_pkg::ADDR_ANIM_EN ||
            a == core_pkg::ADDR_DEBUG || a == core_pkg::ADDR_SIGNED ||
            a == core_pkg::ADDR_FRAME_CNT) begin
            a = 32'hF8000000;
        end
        return a;
    endfunction

    task automatic drive_write(input logic [31:0] a, input logic [31:0] d);
        @(posedge clk_74a);
        bridge <= '{addr: a, rd: 1'b0, wr: 1'b1, wr_data: d};
    endtask

    task automatic drive_read(input logic [31:0] a);
        @(posedge clk_74a);
        bridge <= '{addr: a, rd: 1'b1, wr: 1'b0, wr_data: 32'd0};
    endtask

    // read in the next cycle, sampled mid-cycle
    task automatic read_check(input logic [31:0] a, input logic [31:0] exp,
                              input string name);
        drive_read(a);
        @(negedge clk_74a);
        check_value(name, bridge_rd_data, exp);
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    always @(posedge clk_74a) begin
        if (rst) begin
            m_regs.chan_en      <= 3'b111;
            m_regs.anim_en      <= 1'b1;
            m_regs.debug_value  <= 32'h12005678;
            m_regs.signed_value <= '0;
            m_clear             <= 1'b0;
            m_incr              <= 1'b0;
            m_audio             <= '0;
            m_count             <= '0;
        end else begin
            if (bridge.wr) begin
                case (bridge.addr)
                    32'h00F0000C: m_regs.chan_en      <= bridge.wr_data[2:0];
                    32'h00100000: m_regs.anim_en      <= bridge.wr_data[0];
                    32'h00100004: m_regs.debug_value  <= bridge.wr_data;
                    32'h00300000: m_regs.signed_value <= bridge.wr_data;
                    default: ;
                endcase
            end
            m_clear <= bridge.wr && (bridge.addr == 32'h00F00014);
            m_incr  <= bridge.wr && (bridge.addr == 32'h00F00018);
            m_audio <= audio_step(m_audio);
            // clear wins, else incr and frame end both count
            if (m_clear) begin
                m_count <= '0;
            end else begin
                m_count <= m_count + 16'(m_incr) + 16'(m_audio.frame_done);
            end
        end
    end

    // every-cycle compare of outputs against the model
    always @(negedge clk_74a) begin
        if (rst) begin
            prev_sclk  = 1'b0;
            prev_lrck  = 1'b0;
            sclk_falls = 0;
        end else begin
            check_value("audio.mclk", {31'd0, audio.mclk}, {31'd0, m_audio.mclk});
            check_value("audio.sclk", {31'd0, audio.sclk}, {31'd0, m_audio.div[1]});
            check_value("audio.lrck", {31'd0, audio.lrck}, {31'd0, m_audio.lrck});
            check_value("video_cfg", {28'd0, video_cfg},
                        {28'd0, m_regs.chan_en, m_regs.anim_en});
            check_value("bridge_rd_data", bridge_rd_data, model_read(bridge.addr));
            if (prev_sclk && !audio.sclk) begin
                sclk_falls++;
            end
            // one slot is exactly SLOT_BITS sclk falls
            if (audio.lrck != prev_lrck) begin
                check_value("sclk falls per slot", sclk_falls, SLOT_BITS);
                sclk_falls = 0;
                lrck_toggles++;
            end
            prev_sclk = audio.sclk;
            prev_lrck = audio.lrck;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [1:0]  sel;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] exp;
        logic [31:0] snap [4];
        logic [15:0] c0;
        int          waited;
        logic        found;

        rst          = 1'b1;
        bridge       = '0;
        lfsr         = 32'h94dfc4c9;
        lrck_toggles = 0;

        repeat (5) @(posedge clk_74a);
        rst <= 1'b0;

        // reset state, before the first mclk toggle
        @(negedge clk_74a);
        check_value("video_cfg", {28'd0, video_cfg}, 32'h0000000F);
        check_value("audio", {29'd0, audio}, 32'd0);
        read_check(core_pkg::ADDR_CHAN_EN, 32'd7, "chan_en reset");
        read_check(core_pkg::ADDR_ANIM_EN, 32'd1, "anim_en reset");
        read_check(core_pkg::ADDR_DEBUG, 32'h12005678, "debug reset");
        read_check(core_pkg::ADDR_SIGNED, 32'd0, "signed reset");
        read_check(core_pkg::ADDR_FRAME_CNT, 32'd0, "frame count reset");

        // random register writes, read back next cycle
        repeat (200) begin
            sel = 2'(rand_bits(2));
            d   = rand_bits(32);
            case (sel)
                2'd0: begin
                    a   = core_pkg::ADDR_CHAN_EN;
                    exp = {29'd0, d[2:0]};
                end
                2'd1: begin
                    a   = core_pkg::ADDR_ANIM_EN;
                    exp = {31'd0, d[0]};
                end
                2'd2: begin
                    a   = core_pkg::ADDR_DEBUG;
                    exp = d;
                end
                default: begin
                    a   = core_pkg::ADDR_SIGNED;
                    exp = d;
                end
            endcase
            drive_write(a, d);
            read_check(a, exp, "register readback");
        end

        // unmapped writes and reads
        snap[0] = model_read(core_pkg::ADDR_CHAN_EN);
        snap[1] = model_read(core_pkg::ADDR_ANIM_EN);
        snap[2] = model_read(core_pkg::ADDR_DEBUG);
        snap[3] = model_read(core_pkg::ADDR_SIGNED);
        repeat (60) begin
            a = unmapped_addr();
            drive_write(a, rand_bits(32));
            read_check(a, 32'd0, "unmapped read");
        end
        read_check(core_pkg::ADDR_CHAN_EN, snap[0], "chan_en after unmapped");
        read_check(core_pkg::ADDR_ANIM_EN, snap[1], "anim_en after unmapped");
        read_check(core_pkg::ADDR_DEBUG, snap[2], "debug after unmapped");
        read_check(core_pkg::ADDR_SIGNED, snap[3], "signed after unmapped");

        // free-running frames
        drive_read(core_pkg::ADDR_FRAME_CNT);
        repeat (20000) @(posedge clk_74a);
        if (lrck_toggles < 8) begin
            fail_plain("lrck did not keep toggling during the free run");
        end

        // random increments between idle reads
        repeat (100) begin
            repeat (rand_bits(4)) drive_read(core_pkg::ADDR_FRAME_CNT);
            drive_write(core_pkg::ADDR_FRAME_INC, rand_bits(32));
        end

        // increments landing on a frame end
        repeat (3) begin
            drive_read(core_pkg::ADDR_FRAME_CNT);
            @(posedge clk_74a);
            found  = 1'b0;
            waited = 0;
            while (!found) begin
                @(posedge clk_74a);
                // the write is sampled one edge later
                if (frame_ends_from(audio_step(m_audio))) begin
                    found  = 1'b1;
                    c0     = m_count;
                    bridge <= '{addr: core_pkg::ADDR_FRAME_INC, rd: 1'b0, wr: 1'b1,
                                wr_data: 32'd0};
                end else begin
                    waited++;
                    if (waited > TIMEOUT) begin
                        fail_plain("timed out waiting for a frame end");
                    end
                end
            end
            drive_read(core_pkg::ADDR_FRAME_CNT);
            @(posedge clk_74a);
            @(negedge clk_74a);
            check_value("frame count after incr on frame end", bridge_rd_data,
                        {16'd0, c0 + 16'd2});
        end

        // clears mixed with increments
        repeat (8) begin
            repeat (rand_bits(8)) drive_read(core_pkg::ADDR_FRAME_CNT);
            drive_write(core_pkg::ADDR_FRAME_INC, 32'd0);
            drive_read(core_pkg::ADDR_FRAME_CNT);
            drive_write(core_pkg::ADDR_FRAME_RST, rand_bits(32));
            drive_read(core_pkg::ADDR_FRAME_CNT);
            @(posedge clk_74a);
            @(negedge clk_74a);
            check_value("frame count after clear", bridge_rd_data, 32'd0);
        end

        repeat (50) drive_read(core_pkg::ADDR_FRAME_CNT);
        $display("=== PASS ===");
        $finish;
    end

endmodule
